// File: dv/tb_ulpb_ring.sv
`timescale 1ns/1ps
`include "ulpb_macros.svh"

module tb_ulpb_ring;

	localparam int TIMEOUT = 300;
	localparam int P_ACK = 0;
	localparam int P_REQ = 1;
	localparam int P_STATUS = 2;
	localparam int P_BUS = 3;
	localparam bit NODE_A = 1'b0;
	localparam bit NODE_B = 1'b1;
	localparam logic [`ULPB_ADDR_W-1:0] ADDR_A = 8'h1a;
	localparam logic [`ULPB_ADDR_W-1:0] ADDR_B = 8'hab;

	typedef logic [`ULPB_FRAME_W-1:0] word_t;

	logic CLK;
	logic RESET;
	logic [1:0] req_in;
	logic [1:0] ack_in;
	logic [1:0] tx_ack;
	logic [1:0][`ULPB_ADDR_W-1:0] addr_in;
	logic [1:0][`ULPB_DATA_W-1:0] data_in;
	wire [1:0] ack_out;
	wire [1:0] req_out;
	wire [1:0] tx_success;
	wire [1:0] tx_fail;
	wire [1:0][`ULPB_ADDR_W-1:0] addr_out;
	wire [1:0][`ULPB_DATA_W-1:0] data_out;
	wire bus_ab;
	wire bus_ba;
	word_t exp_a [$];
	word_t exp_b [$];
	int errors;
	int fails;

	ulpb_ring_top #(
		.ADDR_A (ADDR_A),
		.ADDR_B (ADDR_B),
		.MASK_A (8'hff),
		.MASK_B (8'hff)
	) u_dut (
		.CLK (CLK),
		.RESET (RESET),
		.ADDR_IN_a (addr_in[0]), .DATA_IN_a (data_in[0]), .REQ_IN_FROM_LC_a (req_in[0]),
		.ACK_OUT_TO_LC_a (ack_out[0]), .ADDR_OUT_a (addr_out[0]), .DATA_OUT_a (data_out[0]),
		.REQ_OUT_TO_LC_a (req_out[0]), .ACK_IN_FROM_LC_a (ack_in[0]),
		.TX_FAIL_a (tx_fail[0]), .TX_SUCCESS_a (tx_success[0]), .TX_ACK_a (tx_ack[0]),
		.ADDR_IN_b (addr_in[1]), .DATA_IN_b (data_in[1]), .REQ_IN_FROM_LC_b (req_in[1]),
		.ACK_OUT_TO_LC_b (ack_out[1]), .ADDR_OUT_b (addr_out[1]), .DATA_OUT_b (data_out[1]),
		.REQ_OUT_TO_LC_b (req_out[1]), .ACK_IN_FROM_LC_b (ack_in[1]),
		.TX_FAIL_b (tx_fail[1]), .TX_SUCCESS_b (tx_success[1]), .TX_ACK_b (tx_ack[1]),
		.BUS_AB (bus_ab),
		.BUS_BA (bus_ba)
	);

	always #20 CLK = ~CLK;

	function automatic string sfx(input bit side);
		return (side == NODE_A) ? "a" : "b";
	endfunction

	function automatic logic probe(input int kind, input bit side);
		case (kind)
			P_ACK: return ack_out[side];
			P_REQ: return req_out[side];
			P_STATUS: return tx_success[side] | tx_fail[side];
			default: return (side == NODE_A) ? bus_ab : bus_ba;
		endcase
	endfunction

	// sample and drive point, just after the rising edge.
	task automatic step();
		@(posedge CLK);
		#2;
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else
		begin
			errors++;
			$display("MISMATCH %s exp %0h got %0h", name, exp, got);
		end
	endtask

	task automatic wait_for(input int kind, input bit side, input logic level, input string what);
		int n;
		n = 0;
		while (probe(kind, side) !== level && n < TIMEOUT)
		begin
			step();
			n++;
		end
		if (probe(kind, side) !== level)
		begin
			errors++;
			$display("timeout waiting for %s on node %s", what, sfx(side));
		end
	endtask

	// frame goes to the far node's expected queue when deliver is set.
	task automatic request_write(input bit side, input logic [`ULPB_ADDR_W-1:0] addr,
		input bit deliver);
		addr_in[side] = addr;
		data_in[side] = $urandom;
		req_in[side] = 1'b1;
		if (deliver && side == NODE_A)
			exp_b.push_back({addr, data_in[side]});
		else if (deliver)
			exp_a.push_back({addr, data_in[side]});
	endtask

	task automatic finish_write(input bit side);
		wait_for(P_ACK, side, 1'b1, "ACK_OUT_TO_LC");
		req_in[side] = 1'b0;
		wait_for(P_ACK, side, 1'b0, "ACK_OUT_TO_LC to fall");
	endtask

	task automatic send(input bit side, input logic [`ULPB_ADDR_W-1:0] addr, input bit deliver);
		request_write(side, addr, deliver);
		finish_write(side);
	endtask

	task automatic expect_rx(input bit side);
		word_t exp;
		bit have;
		wait_for(P_REQ, side, 1'b1, "REQ_OUT_TO_LC");
		have = (side == NODE_A) ? (exp_a.size() > 0) : (exp_b.size() > 0);
		assert (have) else
		begin
			errors++;
			$display("frame at node %s with none expected", sfx(side));
		end
		if (have)
		begin
			if (side == NODE_A)
				exp = exp_a.pop_front();
			else
				exp = exp_b.pop_front();
			check_value({"ADDR_OUT_", sfx(side)}, word_t'(addr_out[side]),
				exp >> `ULPB_DATA_W);
			check_value({"DATA_OUT_", sfx(side)}, word_t'(data_out[side]),
				word_t'(exp[`ULPB_DATA_W-1:0]));
		end
		ack_in[side] = 1'b1;
		wait_for(P_REQ, side, 1'b0, "REQ_OUT_TO_LC to fall");
		ack_in[side] = 1'b0;
	endtask

	task automatic expect_status(input bit side, input bit success);
		wait_for(P_STATUS, side, 1'b1, "a transmit status");
		check_value({"TX_SUCCESS_", sfx(side)}, word_t'(tx_success[side]), word_t'(success));
		check_value({"TX_FAIL_", sfx(side)}, word_t'(tx_fail[side]), word_t'(!success));
		tx_ack[side] = 1'b1;
		step();
		tx_ack[side] = 1'b0;
		check_value({"TX status after TX_ACK_", sfx(side)}, word_t'(probe(P_STATUS, side)), '0);
	endtask

	initial
	begin
		CLK = 1'b0;
		RESET = 1'b0;
		req_in = '0;
		ack_in = '0;
		tx_ack = '0;
		addr_in = '0;
		data_in = '0;
		errors = 0;
		void'($urandom(91930));
		repeat (10) @(posedge CLK);
		#2;
		RESET = 1'b1;

		check_value("BUS_AB", word_t'(bus_ab), word_t'(1));
		check_value("BUS_BA", word_t'(bus_ba), word_t'(1));
		check_value("ACK_OUT_TO_LC", word_t'(ack_out), '0);
		check_value("REQ_OUT_TO_LC", word_t'(req_out), '0);
		check_value("TX_SUCCESS", word_t'(tx_success), '0);
		check_value("TX_FAIL", word_t'(tx_fail), '0);

		send(NODE_A, ADDR_B, 1'b1);
		expect_rx(NODE_B);
		expect_status(NODE_A, 1'b1);

		// a REQ at B would still be up when the status arrives.
		send(NODE_A, 8'h55, 1'b0);
		expect_status(NODE_A, 1'b0);
		check_value("REQ_OUT_TO_LC_b", word_t'(req_out[NODE_B]), '0);

		// B leaves its first frame unread.
		send(NODE_A, ADDR_B, 1'b1);
		expect_status(NODE_A, 1'b1);
		send(NODE_A, ADDR_B, 1'b0);
		expect_status(NODE_A, 1'b0);
		expect_rx(NODE_B);
		send(NODE_A, ADDR_B, 1'b1);
		expect_rx(NODE_B);
		expect_status(NODE_A, 1'b1);

		for (int i = 0; i < 5; i++)
			send(NODE_A, ADDR_B, 1'b1);
		for (int i = 0; i < 5; i++)
		begin
			expect_rx(NODE_B);
			expect_status(NODE_A, 1'b1);
		end
		for (int i = 0; i < 5; i++)
			send(NODE_B, ADDR_A, 1'b1);
		for (int i = 0; i < 5; i++)
		begin
			expect_rx(NODE_A);
			expect_status(NODE_B, 1'b1);
		end

		// unacknowledged status stalls A, so seven entries fill its FIFO.
		send(NODE_A, ADDR_B, 1'b1);
		wait_for(P_BUS, NODE_A, 1'b0, "start bit on BUS_AB");
		for (int i = 0; i < 7; i++)
			send(NODE_A, ADDR_B, 1'b1);
		request_write(NODE_A, ADDR_B, 1'b1);
		wait_for(P_STATUS, NODE_A, 1'b1, "a transmit status");
		// bus goes idle while the status is held.
		for (int i = 0; i < 2 * `ULPB_IDLE_GAP; i++)
		begin
			step();
			check_value("ACK_OUT_TO_LC_a", word_t'(ack_out[NODE_A]), '0);
		end
		expect_rx(NODE_B);
		expect_status(NODE_A, 1'b1);
		finish_write(NODE_A);
		for (int i = 0; i < 8; i++)
		begin
			expect_rx(NODE_B);
			expect_status(NODE_A, 1'b1);
		end

		fails = u_dut.u_chk.fail_cnt;
		$display("errors: %0d in testbench checks, %0d in assertions", errors, fails);
		if (errors == 0 && fails == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: dv/ulpb_ring_chk.sv
`timescale 1ns/1ps
`include "ulpb_macros.svh"

module ulpb_ring_chk
(
	input logic                          CLK,
	input logic                          RESET,
	input logic [1:0]                    req_in,
	input logic [1:0]                    ack_out,
	input logic [1:0]                    req_out,
	input logic [1:0][`ULPB_FRAME_W-1:0] rx_word,
	input logic [1:0]                    tx_success,
	input logic [1:0]                    tx_fail,
	input logic [1:0]                    tx_ack
);

	int fail_cnt = 0;

	// write ACK only answers a pending request.
	a_ack_needs_req: assert property (@(posedge CLK) disable iff (!RESET)
		(ack_out & ~$past(ack_out) & ~$past(req_in)) == 2'b00) else
	begin
		fail_cnt++;
		$error("ACK_OUT_TO_LC rose without REQ_IN_FROM_LC");
	end

	a_one_status: assert property (@(posedge CLK) disable iff (!RESET)
		(tx_success & tx_fail) == 2'b00) else
	begin
		fail_cnt++;
		$error("TX_SUCCESS and TX_FAIL high together");
	end

	a_rx_stable_a: assert property (@(posedge CLK) disable iff (!RESET)
		req_out[0] && $past(req_out[0]) |-> $stable(rx_word[0])) else
	begin
		fail_cnt++;
		$error("node a receive word changed while REQ_OUT_TO_LC high");
	end

	a_rx_stable_b: assert property (@(posedge CLK) disable iff (!RESET)
		req_out[1] && $past(req_out[1]) |-> $stable(rx_word[1])) else
	begin
		fail_cnt++;
		$error("node b receive word changed while REQ_OUT_TO_LC high");
	end

	// a held status only drops after TX_ACK.
	a_status_hold: assert property (@(posedge CLK) disable iff (!RESET)
		((($past(tx_success) & ~tx_success) | ($past(tx_fail) & ~tx_fail))
			& ~$past(tx_ack)) == 2'b00) else
	begin
		fail_cnt++;
		$error("transmit status dropped without TX_ACK");
	end

endmodule

bind ulpb_ring_top ulpb_ring_chk u_chk
(
	.CLK        (CLK),
	.RESET      (RESET),
	.req_in     ({REQ_IN_FROM_LC_b, REQ_IN_FROM_LC_a}),
	.ack_out    ({ACK_OUT_TO_LC_b, ACK_OUT_TO_LC_a}),
	.req_out    ({REQ_OUT_TO_LC_b, REQ_OUT_TO_LC_a}),
	.rx_word    ({ADDR_OUT_b, DATA_OUT_b, ADDR_OUT_a, DATA_OUT_a}),
	.tx_success ({TX_SUCCESS_b, TX_SUCCESS_a}),
	.tx_fail    ({TX_FAIL_b, TX_FAIL_a}),
	.tx_ack     ({TX_ACK_b, TX_ACK_a})
);

// File: include/ulpb_macros.svh
`ifndef ULPB_MACROS_SVH
`define ULPB_MACROS_SVH

// frame fields.
`define ULPB_ADDR_W 8
`define ULPB_DATA_W 32
`define ULPB_FRAME_W (`ULPB_ADDR_W + `ULPB_DATA_W)

// one slot stays empty, so seven entries fit.
`define ULPB_FIFO_DEPTH 8

// high cycles on DIN before the bus counts as idle.
`define ULPB_IDLE_GAP 12

// acknowledge timing, counted from the stop bit.
`define ULPB_ACK_DLY 2
`define ULPB_ACK_LEN 2
`define ULPB_ACK_WINDOW 8

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the ring testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_ulpb_ring

# keep running past assertion errors so the testbench prints its summary
./obj_dir/Vtb_ulpb_ring +verilator+error+limit+1000 | tee sim.log

grep -qx "PASS: all tests" sim.log

// File: src.f
+incdir+include
verilog/ulpb_pkg.sv
verilog/ulpb_tx_fifo.sv
verilog/ulpb_tx_serializer.sv
verilog/ulpb_rx_deserializer.sv
verilog/ulpb_node_ctrl.sv
verilog/ulpb_node_top.sv
verilog/ulpb_ring_top.sv
dv/ulpb_ring_chk.sv
dv/tb_ulpb_ring.sv

// File: verilog/ulpb_node_ctrl.sv
`timescale 1ns/1ps
`include "ulpb_macros.svh"

module ulpb_node_ctrl import ulpb_pkg::*;
(
	input  logic CLK,
	input  logic RESET,
	input  logic DIN,
	output logic DOUT,
	input  logic fifo_empty,
	input  logic tx_bit,
	input  logic addr_match,
	input  logic rx_busy,
	output logic frame_load,
	output logic tx_shift,
	output logic rx_shift,
	output logic frame_done,
	output logic TX_SUCCESS,
	output logic TX_FAIL,
	input  logic TX_ACK
);

	localparam int CNT_W = $clog2(`ULPB_FRAME_W + 1);
	localparam int GAP_W = $clog2(`ULPB_IDLE_GAP + 1);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`ULPB_FRAME_W);
	localparam logic [CNT_W-1:0] WIN_END = CNT_W'(`ULPB_ACK_WINDOW);
	localparam logic [CNT_W-1:0] ACK_END = CNT_W'(`ULPB_ACK_DLY + `ULPB_ACK_LEN);
	localparam logic [GAP_W-1:0] GAP_MAX = GAP_W'(`ULPB_IDLE_GAP);

	ulpb_ctrl_state_e state;
	logic [CNT_W-1:0] bit_cnt;
	logic [CNT_W-1:0] cnt_next;
	logic [GAP_W-1:0] gap_cnt;
	logic dout_q;
	logic ack_seen;
	logic ack_now;
	logic bus_idle;
	logic status_held;

	// n counts cycles after the stop bit.
	function automatic logic ack_low(input logic [CNT_W-1:0] n);
		return (n >= CNT_W'(`ULPB_ACK_DLY)) && (n < ACK_END);
	endfunction

	assign DOUT = dout_q;
	assign cnt_next = bit_cnt + CNT_W'(1);
	assign bus_idle = (gap_cnt == GAP_MAX);
	assign status_held = TX_SUCCESS | TX_FAIL;
	assign ack_now = ack_seen | !DIN;

	// DIN high in IDLE, so a start bit takes priority.
	assign frame_load = (state == IDLE) && DIN && bus_idle && !fifo_empty && !status_held;
	assign tx_shift = (state == TX_FRAME) && (bit_cnt != LAST_BIT);
	assign rx_shift = (state == RX_FRAME) && (bit_cnt != LAST_BIT);
	assign frame_done = (state == RX_FRAME) && (bit_cnt == LAST_BIT) && DIN;

	// idle gap, own line must be high too.
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			gap_cnt <= '0;
		else if (!(DIN && dout_q))
			gap_cnt <= '0;
		else if (!bus_idle)
			gap_cnt <= gap_cnt + GAP_W'(1);
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= IDLE;
			bit_cnt <= '0;
			dout_q <= 1'b1;
			ack_seen <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					bit_cnt <= '0;
					if (!DIN)
						state <= RX_FRAME;
					else if (frame_load)
					begin
						state <= TX_FRAME;
						dout_q <= 1'b0;
					end
				end
				TX_FRAME:
				begin
					if (tx_shift)
					begin
						dout_q <= tx_bit;
						bit_cnt <= cnt_next;
					end
					else
					begin
						// stop bit, then listen.
						dout_q <= 1'b1;
						bit_cnt <= '0;
						ack_seen <= 1'b0;
						state <= TX_WAIT_ACK;
					end
				end
				TX_WAIT_ACK:
				begin
					bit_cnt <= cnt_next;
					if ((bit_cnt != '0) && !DIN)
						ack_seen <= 1'b1;
					if (bit_cnt == WIN_END)
						state <= IDLE;
				end
				RX_FRAME:
				begin
					if (rx_shift)
						bit_cnt <= cnt_next;
					else
					begin
						bit_cnt <= CNT_W'(1);
						if (frame_done && addr_match && !rx_busy)
						begin
							dout_q <= !ack_low(CNT_W'(1));
							state <= RX_SEND_ACK;
						end
						else
							state <= IDLE;
					end
				end
				RX_SEND_ACK:
				begin
					bit_cnt <= cnt_next;
					dout_q <= !ack_low(cnt_next);
					if (cnt_next >= ACK_END)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// status held as a level until the LC acknowledges it.
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			TX_SUCCESS <= 1'b0;
			TX_FAIL <= 1'b0;
		end
		else if (TX_ACK)
		begin
			TX_SUCCESS <= 1'b0;
			TX_FAIL <= 1'b0;
		end
		else if ((state == TX_WAIT_ACK) && (bit_cnt == WIN_END))
		begin
			TX_SUCCESS <= ack_now;
			TX_FAIL <= !ack_now;
		end
	end

endmodule

// File: verilog/ulpb_node_top.sv
`timescale 1ns/1ps
`include "ulpb_macros.svh"

module ulpb_node_top import ulpb_pkg::*;
#(
	parameter logic [`ULPB_ADDR_W-1:0] ADDRESS = 8'hab,
	parameter logic [`ULPB_ADDR_W-1:0] ADDRESS_MASK = 8'hff
)
(
	input  logic                    CLK,
	input  logic                    RESET,
	input  logic                    DIN,
	output logic                    DOUT,
	input  logic [`ULPB_ADDR_W-1:0] ADDR_IN,
	input  logic [`ULPB_DATA_W-1:0] DATA_IN,
	input  logic                    REQ_IN_FROM_LC,
	output logic                    ACK_OUT_TO_LC,
	output logic [`ULPB_ADDR_W-1:0] ADDR_OUT,
	output logic [`ULPB_DATA_W-1:0] DATA_OUT,
	output logic                    REQ_OUT_TO_LC,
	input  logic                    ACK_IN_FROM_LC,
	output logic                    TX_FAIL,
	output logic                    TX_SUCCESS,
	input  logic                    TX_ACK
);

	ulpb_frame_u head_frame;
	logic fifo_empty;
	logic frame_load;
	logic tx_shift;
	logic tx_bit;
	logic rx_shift;
	logic frame_done;
	logic addr_match;
	logic rx_busy;

	// frame_load also pops the queue.
	ulpb_tx_fifo u_tx_fifo
	(
		.CLK            (CLK),
		.RESET          (RESET),
		.REQ_IN_FROM_LC (REQ_IN_FROM_LC),
		.ADDR_IN        (ADDR_IN),
		.DATA_IN        (DATA_IN),
		.ACK_OUT_TO_LC  (ACK_OUT_TO_LC),
		.pop            (frame_load),
		.head_frame     (head_frame),
		.empty          (fifo_empty)
	);

	ulpb_tx_serializer u_tx_ser
	(
		.CLK        (CLK),
		.RESET      (RESET),
		.frame_load (frame_load),
		.frame_in   (head_frame),
		.shift      (tx_shift),
		.tx_bit     (tx_bit)
	);

	ulpb_rx_deserializer #(
		.ADDRESS      (ADDRESS),
		.ADDRESS_MASK (ADDRESS_MASK)
	) u_rx_deser (
		.CLK            (CLK),
		.RESET          (RESET),
		.DIN            (DIN),
		.shift          (rx_shift),
		.frame_done     (frame_done),
		.addr_match     (addr_match),
		.rx_busy        (rx_busy),
		.ADDR_OUT       (ADDR_OUT),
		.DATA_OUT       (DATA_OUT),
		.REQ_OUT_TO_LC  (REQ_OUT_TO_LC),
		.ACK_IN_FROM_LC (ACK_IN_FROM_LC)
	);

	ulpb_node_ctrl u_ctrl
	(
		.CLK        (CLK),
		.RESET      (RESET),
		.DIN        (DIN),
		.DOUT       (DOUT),
		.fifo_empty (fifo_empty),
		.tx_bit     (tx_bit),
		.addr_match (addr_match),
		.rx_busy    (rx_busy),
		.frame_load (frame_load),
		.tx_shift   (tx_shift),
		.rx_shift   (rx_shift),
		.frame_done (frame_done),
		.TX_SUCCESS (TX_SUCCESS),
		.TX_FAIL    (TX_FAIL),
		.TX_ACK     (TX_ACK)
	);

endmodule

// File: verilog/ulpb_pkg.sv
`include "ulpb_macros.svh"

package ulpb_pkg;

	// a frame word, shifted as flat bits or read as fields.
	typedef union packed
	{
		logic [`ULPB_FRAME_W-1:0] bits;
		struct packed
		{
			logic [`ULPB_ADDR_W-1:0] addr;
			logic [`ULPB_DATA_W-1:0] data;
		} f;
	} ulpb_frame_u;

	typedef enum logic [2:0]
	{
		IDLE,
		TX_FRAME,
		TX_WAIT_ACK,
		RX_FRAME,
		RX_SEND_ACK
	} ulpb_ctrl_state_e;

endpackage

// File: verilog/ulpb_ring_top.sv
`timescale 1ns/1ps
`include "ulpb_macros.svh"

module ulpb_ring_top
#(
	parameter logic [`ULPB_ADDR_W-1:0] ADDR_A = 8'h1a,
	parameter logic [`ULPB_ADDR_W-1:0] ADDR_B = 8'hab,
	parameter logic [`ULPB_ADDR_W-1:0] MASK_A = 8'hff,
	parameter logic [`ULPB_ADDR_W-1:0] MASK_B = 8'hff
)
(
	input  logic                    CLK,
	input  logic                    RESET,
	input  logic [`ULPB_ADDR_W-1:0] ADDR_IN_a,
	input  logic [`ULPB_DATA_W-1:0] DATA_IN_a,
	input  logic                    REQ_IN_FROM_LC_a,
	output logic                    ACK_OUT_TO_LC_a,
	output logic [`ULPB_ADDR_W-1:0] ADDR_OUT_a,
	output logic [`ULPB_DATA_W-1:0] DATA_OUT_a,
	output logic                    REQ_OUT_TO_LC_a,
	input  logic                    ACK_IN_FROM_LC_a,
	output logic                    TX_FAIL_a,
	output logic                    TX_SUCCESS_a,
	input  logic                    TX_ACK_a,
	input  logic [`ULPB_ADDR_W-1:0] ADDR_IN_b,
	input  logic [`ULPB_DATA_W-1:0] DATA_IN_b,
	input  logic                    REQ_IN_FROM_LC_b,
	output logic                    ACK_OUT_TO_LC_b,
	output logic [`ULPB_ADDR_W-1:0] ADDR_OUT_b,
	output logic [`ULPB_DATA_W-1:0] DATA_OUT_b,
	output logic                    REQ_OUT_TO_LC_b,
	input  logic                    ACK_IN_FROM_LC_b,
	output logic                    TX_FAIL_b,
	output logic                    TX_SUCCESS_b,
	input  logic                    TX_ACK_b,
	output logic                    BUS_AB,
	output logic                    BUS_BA
);

	// A drives B on BUS_AB, B closes the ring on BUS_BA.
	ulpb_node_top #(
		.ADDRESS      (ADDR_A),
		.ADDRESS_MASK (MASK_A)
	) u_node_a (
		.CLK            (CLK),
		.RESET          (RESET),
		.DIN            (BUS_BA),
		.DOUT           (BUS_AB),
		.ADDR_IN        (ADDR_IN_a),
		.DATA_IN        (DATA_IN_a),
		.REQ_IN_FROM_LC (REQ_IN_FROM_LC_a),
		.ACK_OUT_TO_LC  (ACK_OUT_TO_LC_a),
		.ADDR_OUT       (ADDR_OUT_a),
		.DATA_OUT       (DATA_OUT_a),
		.REQ_OUT_TO_LC  (REQ_OUT_TO_LC_a),
		.ACK_IN_FROM_LC (ACK_IN_FROM_LC_a),
		.TX_FAIL        (TX_FAIL_a),
		.TX_SUCCESS     (TX_SUCCESS_a),
		.TX_ACK         (TX_ACK_a)
	);

	ulpb_node_top #(
		.ADDRESS      (ADDR_B),
		.ADDRESS_MASK (MASK_B)
	) u_node_b (
		.CLK            (CLK),
		.RESET          (RESET),
		.DIN            (BUS_AB),
		.DOUT           (BUS_BA),
		.ADDR_IN        (ADDR_IN_b),
		.DATA_IN        (DATA_IN_b),
		.REQ_IN_FROM_LC (REQ_IN_FROM_LC_b),
		.ACK_OUT_TO_LC  (ACK_OUT_TO_LC_b),
		.ADDR_OUT       (ADDR_OUT_b),
		.DATA_OUT       (DATA_OUT_b),
		.REQ_OUT_TO_LC  (REQ_OUT_TO_LC_b),
		.ACK_IN_FROM_LC (ACK_IN_FROM_LC_b),
		.TX_FAIL        (TX_FAIL_b),
		.TX_SUCCESS     (TX_SUCCESS_b),
		.TX_ACK         (TX_ACK_b)
	);

endmodule

// File: verilog/ulpb_rx_deserializer.sv
`timescale 1ns/1ps
`include "ulpb_macros.svh"

module ulpb_rx_deserializer import ulpb_pkg::*;
#(
	parameter logic [`ULPB_ADDR_W-1:0] ADDRESS = 8'hab,
	parameter logic [`ULPB_ADDR_W-1:0] ADDRESS_MASK = 8'hff
)
(
	input  logic                    CLK,
	input  logic                    RESET,
	input  logic                    DIN,
	input  logic                    shift,
	input  logic                    frame_done,
	output logic                    addr_match,
	output logic                    rx_busy,
	output logic [`ULPB_ADDR_W-1:0] ADDR_OUT,
	output logic [`ULPB_DATA_W-1:0] DATA_OUT,
	output logic                    REQ_OUT_TO_LC,
	input  logic                    ACK_IN_FROM_LC
);

	ulpb_frame_u sr;
	ulpb_frame_u held;
	logic capture;

	// only bits set in the mask take part in the compare.
	assign addr_match = (((sr.f.addr ^ ADDRESS) & ADDRESS_MASK) == '0);

	// buffer stays taken until the LC has read it.
	assign rx_busy = REQ_OUT_TO_LC;

	assign capture = frame_done && addr_match && !REQ_OUT_TO_LC;

	assign ADDR_OUT = held.f.addr;
	assign DATA_OUT = held.f.data;

	always_ff @(posedge CLK)
	begin
		if (shift)
			sr.bits <= {sr.bits[`ULPB_FRAME_W-2:0], DIN};
	end

	always_ff @(posedge CLK)
	begin
		if (capture)
			held <= sr;
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			REQ_OUT_TO_LC <= 1'b0;
		else if (capture)
			REQ_OUT_TO_LC <= 1'b1;
		else if (REQ_OUT_TO_LC && ACK_IN_FROM_LC)
			REQ_OUT_TO_LC <= 1'b0;
	end

endmodule

// File: verilog/ulpb_tx_fifo.sv
`timescale 1ns/1ps
`include "ulpb_macros.svh"

module ulpb_tx_fifo import ulpb_pkg::*;
(
	input  logic                    CLK,
	input  logic                    RESET,
	input  logic                    REQ_IN_FROM_LC,
	input  logic [`ULPB_ADDR_W-1:0] ADDR_IN,
	input  logic [`ULPB_DATA_W-1:0] DATA_IN,
	output logic                    ACK_OUT_TO_LC,
	input  logic                    pop,
	output ulpb_frame_u             head_frame,
	output logic                    empty
);

	localparam int PTR_W = $clog2(`ULPB_FIFO_DEPTH);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`ULPB_FIFO_DEPTH - 1);

	ulpb_frame_u mem [`ULPB_FIFO_DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] head_next;
	logic [PTR_W-1:0] tail_next;
	logic full;
	logic write;

	assign head_next = (head == LAST_SLOT) ? '0 : head + PTR_W'(1);
	assign tail_next = (tail == LAST_SLOT) ? '0 : tail + PTR_W'(1);

	assign empty = (head == tail);
	assign full = (head_next == tail);

	// one entry per handshake; ACK high blocks a second write.
	assign write = REQ_IN_FROM_LC && !ACK_OUT_TO_LC && !full;

	// oldest entry.
	assign head_frame = mem[tail];

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			head <= '0;
			tail <= '0;
			ACK_OUT_TO_LC <= 1'b0;
		end
		else
		begin
			if (write)
			begin
				head <= head_next;
				ACK_OUT_TO_LC <= 1'b1;
			end
			else if (ACK_OUT_TO_LC && !REQ_IN_FROM_LC)
				ACK_OUT_TO_LC <= 1'b0;

			if (pop && !empty)
				tail <= tail_next;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (write)
		begin
			mem[head].f.addr <= ADDR_IN;
			mem[head].f.data <= DATA_IN;
		end
	end

endmodule

// File: verilog/ulpb_tx_serializer.sv
`timescale 1ns/1ps
`include "ulpb_macros.svh"

module ulpb_tx_serializer import ulpb_pkg::*;
(
	input  logic        CLK,
	input  logic        RESET,
	input  logic        frame_load,
	input  ulpb_frame_u frame_in,
	input  logic        shift,
	output logic        tx_bit
);

	ulpb_frame_u sr;

	// address goes out first, MSB first.
	assign tx_bit = sr.bits[`ULPB_FRAME_W-1];

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			sr.bits <= '0;
		else if (frame_load)
			sr <= frame_in;
		else if (shift)
			sr.bits <= {sr.bits[`ULPB_FRAME_W-2:0], 1'b0};
	end

endmodule
